/* list.f */
design/mfp_pkg.sv
design/mfp_uart_receiver.sv
design/mfp_uart_transmitter.sv
design/mfp_uart_ahb_bridge.sv
design/mfp_ahb_gpio.sv
design/mfp_single_digit_seven_segment_display.sv
design/de10_lite.sv
sim/mfp_bridge_properties.sv
sim/tb_de10_lite.sv

/* Bender.yml */
package:
  name: mfp_de10_lite

sources:
  - design/mfp_pkg.sv
  - design/mfp_uart_receiver.sv
  - design/mfp_uart_transmitter.sv
  - design/mfp_uart_ahb_bridge.sv
  - design/mfp_ahb_gpio.sv
  - design/mfp_single_digit_seven_segment_display.sv
  - design/de10_lite.sv
  - target: simulation
    files:
      - sim/mfp_bridge_properties.sv
      - sim/tb_de10_lite.sv

/* sim/tb_de10_lite.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_de10_lite
    import mfp_pkg::*;
();

    localparam int seed           = 65;
    localparam int n_write_frames = 20;
    localparam int n_read_frames  = 30;
    localparam int frame_bytes    = 6;
    localparam int byte_clks      = 10 * mfp_uart_clks_per_bit;
    // serial time of all frames plus half again
    localparam int timeout_cycles =
        (n_write_frames + n_read_frames) * frame_bytes * byte_clks * 3 / 2;

    localparam logic [7:0] led_offset = 8'(mfp_red_leds_addr - mfp_gpio_base);
    localparam logic [7:0] sw_offset  = 8'(mfp_switches_addr - mfp_gpio_base);
    localparam logic [7:0] btn_offset = 8'(mfp_buttons_addr - mfp_gpio_base);
    localparam logic [7:0] hex_offset = 8'(mfp_7_segment_hex_addr - mfp_gpio_base);

    logic                               clk;
    logic [1:0]                         key;
    logic [mfp_n_switches-1:0]          sw;
    logic                               uart_rx;
    logic                               uart_tx;
    logic [mfp_n_red_leds-1:0]          ledr;
    logic [47:0]                        hex_bus;

    // register model
    logic [mfp_n_red_leds-1:0]          led_model;
    logic [mfp_7_segment_hex_width-1:0] hex_model;

    int          checks            = 0;
    int          errors            = 0;
    int          tests             = 0;
    int          failed_tests      = 0;
    int          test_start_errors = 0;
    int unsigned cycle_count       = 0;

    de10_lite dut_i (
        .max10_clk1_50 (clk),
        .key           (key),
        .sw            (sw),
        .uart_rx       (uart_rx),
        .uart_tx       (uart_tx),
        .ledr          (ledr),
        .hex0          (hex_bus[7:0]),
        .hex1          (hex_bus[15:8]),
        .hex2          (hex_bus[23:16]),
        .hex3          (hex_bus[31:24]),
        .hex4          (hex_bus[39:32]),
        .hex5          (hex_bus[47:40])
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // segment table with lit segments as gfedcba
    function automatic logic [6:0] lit_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // pins against the model with the decimal point dark
    task automatic check_display();
        for (int n = 0; n < 6; n++)
            check_value($sformatf("hex%0d", n), 32'(hex_bus[8*n +: 8]),
                        {24'h0, 1'b1, ~lit_segments(hex_model[4*n +: 4])});
        check_value("ledr", 32'(ledr), 32'(led_model));
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // 8N1 frame sent lsb first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (mfp_uart_clks_per_bit - 1) @(posedge clk);
        end
    endtask

    task automatic receive_byte(output logic [7:0] data);
        @(negedge clk);
        while (uart_tx !== 1'b0)
            @(negedge clk);
        // middle of the start bit
        repeat (mfp_uart_clks_per_bit / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (mfp_uart_clks_per_bit) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (mfp_uart_clks_per_bit) @(negedge clk);
        check_value("uart_tx stop bit", 32'(uart_tx), 32'h1);
    endtask

    task automatic write_frame(input logic [7:0] offset, input logic [31:0] data);
        send_byte(mfp_cmd_write);
        send_byte(offset);
        for (int i = 3; i >= 0; i--)
            send_byte(data[8*i +: 8]);
        repeat (8) @(posedge clk);
    endtask

    task automatic read_frame(input logic [7:0] offset, output logic [31:0] data);
        logic [7:0] rx_byte;
        send_byte(mfp_cmd_read);
        send_byte(offset);
        for (int i = 3; i >= 0; i--) begin
            receive_byte(rx_byte);
            data[8*i +: 8] = rx_byte;
        end
        // bridge drops bytes until the reply is done
        repeat (12) @(posedge clk);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] rdata;
        logic [7:0]  offset;
        void'($urandom(seed));
        clk       = 1'b0;
        key       = 2'b10;
        sw        = '0;
        uart_rx   = 1'b1;
        led_model = '0;
        hex_model = '0;
        repeat (2) @(posedge clk);
        key <= 2'b11;
        repeat (4) @(negedge clk);

        check_value("uart_tx", 32'(uart_tx), 32'h1);
        check_display();
        end_test("reset state");

        for (int i = 0; i < 6; i++) begin
            data = $urandom;
            write_frame(led_offset, data);
            led_model = data[mfp_n_red_leds-1:0];
            check_display();
        end
        end_test("led writes");

        for (int i = 0; i < 6; i++) begin
            data = $urandom;
            write_frame(hex_offset, data);
            hex_model = data[mfp_7_segment_hex_width-1:0];
            check_display();
        end
        end_test("hex writes");

        for (int i = 0; i < 10; i++) begin
            data = $urandom;
            @(posedge clk);
            sw  <= data[mfp_n_switches-1:0];
            key <= {data[10], 1'b1};
            read_frame(sw_offset, rdata);
            check_value("switches", rdata, {22'h0, data[mfp_n_switches-1:0]});
            read_frame(btn_offset, rdata);
            check_value("buttons", rdata, {30'h0, ~data[10], 1'b0});
        end
        end_test("input reads");

        for (int i = 0; i < 2; i++) begin
            data = $urandom;
            write_frame(led_offset, data);
            led_model = data[mfp_n_red_leds-1:0];
            read_frame(led_offset, rdata);
            check_value("led read-back", rdata, {22'h0, led_model});
            data = $urandom;
            write_frame(hex_offset, data);
            hex_model = data[mfp_7_segment_hex_width-1:0];
            read_frame(hex_offset, rdata);
            check_value("hex read-back", rdata, {8'h0, hex_model});
            check_display();
        end
        // switch register is read-only
        for (int i = 0; i < 4; i++) begin
            write_frame(sw_offset, $urandom);
            check_display();
        end
        for (int i = 0; i < 6; i++) begin
            offset = 8'h20 + 8'(4 * ($urandom % 32));
            read_frame(offset, rdata);
            check_value($sformatf("unmapped read 0x%02h", offset), rdata, 32'h0);
        end
        end_test("read-back and unmapped");

        if (dut_i.uart_ahb_bridge.bridge_properties.failures != 0) begin
            $display("bridge bus or serial assertions failed %0d times",
                     dut_i.uart_ahb_bridge.bridge_properties.failures);
            errors += dut_i.uart_ahb_bridge.bridge_properties.failures;
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mfp_bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mfp_bridge_properties
    import mfp_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic [1:0] htrans,
    input logic       hwrite,
    input logic       tx_start,
    input logic       tx_busy
);

    int failures = 0;

    htrans_legal: assert property (@(posedge clk) disable iff (reset)
        htrans == mfp_htrans_idle || htrans == mfp_htrans_nonseq)
        else begin
            $error("htrans holds a code other than IDLE or NONSEQ");
            failures++;
        end

    hwrite_in_nonseq: assert property (@(posedge clk) disable iff (reset)
        hwrite |-> htrans == mfp_htrans_nonseq)
        else begin
            $error("hwrite is high outside an address phase");
            failures++;
        end

    // single transfers only
    nonseq_one_cycle: assert property (@(posedge clk) disable iff (reset)
        htrans == mfp_htrans_nonseq |=> htrans != mfp_htrans_nonseq)
        else begin
            $error("NONSEQ held for two cycles in a row");
            failures++;
        end

    start_when_free: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy)
        else begin
            $error("tx_start raised while the transmitter is busy");
            failures++;
        end

endmodule

bind mfp_uart_ahb_bridge mfp_bridge_properties bridge_properties (
    .clk      (clk),
    .reset    (reset),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
);

`default_nettype wire

/* design/de10_lite.sv */
`timescale 1ns/1ps
`default_nettype none

module de10_lite
    import mfp_pkg::*;
(
    input  logic                      max10_clk1_50,
    input  logic [1:0]                key,
    input  logic [mfp_n_switches-1:0] sw,
    input  logic                      uart_rx,
    output logic                      uart_tx,
    output logic [mfp_n_red_leds-1:0] ledr,
    output logic [7:0]                hex0,
    output logic [7:0]                hex1,
    output logic [7:0]                hex2,
    output logic [7:0]                hex3,
    output logic [7:0]                hex4,
    output logic [7:0]                hex5
);

    logic                               clk;
    logic                               reset;
    logic [7:0]                         rx_data;
    logic                               rx_valid;
    logic [7:0]                         tx_data;
    logic                               tx_start;
    logic                               tx_busy;
    logic [31:0]                        haddr;
    logic [1:0]                         htrans;
    logic                               hwrite;
    logic [31:0]                        hwdata;
    logic [31:0]                        hrdata;
    logic [mfp_7_segment_hex_width-1:0] hex_digits;
    logic [6:0]                         segments [6];

    // no PLL, board clock used directly
    assign clk   = max10_clk1_50;
    assign reset = ~key[0];

    mfp_uart_receiver uart_receiver (
        .clk      (clk),
        .reset    (reset),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    mfp_uart_transmitter uart_transmitter (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (uart_tx),
        .tx_busy  (tx_busy)
    );

    // bridge is the only bus master
    mfp_uart_ahb_bridge uart_ahb_bridge (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hwdata   (hwdata),
        .hrdata   (hrdata)
    );

    mfp_ahb_gpio ahb_gpio (
        .clk        (clk),
        .reset      (reset),
        .haddr      (haddr),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .switches   (sw),
        .buttons    (~key),
        .red_leds   (ledr),
        .hex_digits (hex_digits)
    );

    mfp_single_digit_seven_segment_display digit_0 (
        .digit (hex_digits[3:0]), .seven_segments (segments[0])
    );
    mfp_single_digit_seven_segment_display digit_1 (
        .digit (hex_digits[7:4]), .seven_segments (segments[1])
    );
    mfp_single_digit_seven_segment_display digit_2 (
        .digit (hex_digits[11:8]), .seven_segments (segments[2])
    );
    mfp_single_digit_seven_segment_display digit_3 (
        .digit (hex_digits[15:12]), .seven_segments (segments[3])
    );
    mfp_single_digit_seven_segment_display digit_4 (
        .digit (hex_digits[19:16]), .seven_segments (segments[4])
    );
    mfp_single_digit_seven_segment_display digit_5 (
        .digit (hex_digits[23:20]), .seven_segments (segments[5])
    );

    // decimal points stay dark
    assign hex0 = {1'b1, segments[0]};
    assign hex1 = {1'b1, segments[1]};
    assign hex2 = {1'b1, segments[2]};
    assign hex3 = {1'b1, segments[3]};
    assign hex4 = {1'b1, segments[4]};
    assign hex5 = {1'b1, segments[5]};

endmodule

`default_nettype wire

/* design/mfp_single_digit_seven_segment_display.sv */
`timescale 1ns/1ps
`default_nettype none

module mfp_single_digit_seven_segment_display (
    input  logic [3:0] digit,
    output logic [6:0] seven_segments
);

    // gfedcba, a segment lights when its bit is 0
    always_comb begin
        case (digit)
            4'h0: seven_segments = 7'b100_0000;
            4'h1: seven_segments = 7'b111_1001;
            4'h2: seven_segments = 7'b010_0100;
            4'h3: seven_segments = 7'b011_0000;
            4'h4: seven_segments = 7'b001_1001;
            4'h5: seven_segments = 7'b001_0010;
            4'h6: seven_segments = 7'b000_0010;
            4'h7: seven_segments = 7'b111_1000;
            4'h8: seven_segments = 7'b000_0000;
            4'h9: seven_segments = 7'b001_0000;
            4'ha: seven_segments = 7'b000_1000;
            4'hb: seven_segments = 7'b000_0011;
            4'hc: seven_segments = 7'b100_0110;
            4'hd: seven_segments = 7'b010_0001;
            4'he: seven_segments = 7'b000_0110;
            default: seven_segments = 7'b000_1110;
        endcase
    end

endmodule

`default_nettype wire

/* design/mfp_ahb_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module mfp_ahb_gpio
    import mfp_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [31:0]                        haddr,
    input  logic [1:0]                         htrans,
    input  logic                               hwrite,
    input  logic [31:0]                        hwdata,
    output logic [31:0]                        hrdata,
    input  logic [mfp_n_switches-1:0]          switches,
    input  logic [mfp_n_buttons-1:0]           buttons,
    output logic [mfp_n_red_leds-1:0]          red_leds,
    output logic [mfp_7_segment_hex_width-1:0] hex_digits
);

    logic [31:0]               addr_q;
    logic                      write_q;
    logic                      trans_q;
    logic [mfp_n_switches-1:0] switches_meta;
    logic [mfp_n_switches-1:0] switches_sync;
    logic [mfp_n_buttons-1:0]  buttons_meta;
    logic [mfp_n_buttons-1:0]  buttons_sync;

    // address phase
    always_ff @(posedge clk) begin
        if (reset)
            trans_q <= 1'b0;
        else
            trans_q <= (htrans == mfp_htrans_nonseq);
    end

    always_ff @(posedge clk) begin
        if (htrans == mfp_htrans_nonseq) begin
            addr_q  <= haddr;
            write_q <= hwrite;
        end
    end

    // data phase writes, read-only and unmapped addresses ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            red_leds   <= '0;
            hex_digits <= '0;
        end else if (trans_q && write_q) begin
            if (addr_q == mfp_red_leds_addr)
                red_leds <= hwdata[mfp_n_red_leds-1:0];
            if (addr_q == mfp_7_segment_hex_addr)
                hex_digits <= hwdata[mfp_7_segment_hex_width-1:0];
        end
    end

    // board inputs are asynchronous
    always_ff @(posedge clk) begin
        switches_meta <= switches;
        switches_sync <= switches_meta;
        buttons_meta  <= buttons;
        buttons_sync  <= buttons_meta;
    end

    always_comb begin
        case (addr_q)
            mfp_red_leds_addr:
                hrdata = {{(32 - mfp_n_red_leds){1'b0}}, red_leds};
            mfp_switches_addr:
                hrdata = {{(32 - mfp_n_switches){1'b0}}, switches_sync};
            mfp_buttons_addr:
                hrdata = {{(32 - mfp_n_buttons){1'b0}}, buttons_sync};
            mfp_7_segment_hex_addr:
                hrdata = {{(32 - mfp_7_segment_hex_width){1'b0}}, hex_digits};
            default:
                hrdata = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

/* design/mfp_uart_ahb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module mfp_uart_ahb_bridge
    import mfp_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    output logic [7:0]  tx_data,
    output logic        tx_start,
    input  logic        tx_busy,
    output logic [31:0] haddr,
    output logic [1:0]  htrans,
    output logic        hwrite,
    output logic [31:0] hwdata,
    input  logic [31:0] hrdata
);

    typedef enum logic [2:0] {
        st_command,
        st_offset,
        st_data,
        st_addr_phase,
        st_data_phase,
        st_reply
    } state_t;

    state_t      state;
    logic        is_write;
    logic [1:0]  byte_cnt;
    logic [1:0]  reply_left;
    logic [23:0] reply;
    logic        tx_free;

    // transmitter idle and no strobe in flight
    assign tx_free = !tx_busy && !tx_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_command;
            is_write   <= 1'b0;
            byte_cnt   <= '0;
            reply_left <= '0;
            htrans     <= mfp_htrans_idle;
            hwrite     <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                // unknown command bytes are dropped here
                st_command: begin
                    if (rx_valid && (rx_data == mfp_cmd_write || rx_data == mfp_cmd_read)) begin
                        is_write <= (rx_data == mfp_cmd_write);
                        state    <= st_offset;
                    end
                end
                st_offset: begin
                    if (rx_valid) begin
                        byte_cnt <= '0;
                        if (is_write) begin
                            state <= st_data;
                        end else begin
                            htrans <= mfp_htrans_nonseq;
                            state  <= st_addr_phase;
                        end
                    end
                end
                st_data: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'(mfp_frame_data_bytes - 1)) begin
                            htrans <= mfp_htrans_nonseq;
                            hwrite <= 1'b1;
                            state  <= st_addr_phase;
                        end
                    end
                end
                st_addr_phase: begin
                    htrans <= mfp_htrans_idle;
                    hwrite <= 1'b0;
                    state  <= st_data_phase;
                end
                // hrdata valid now, first reply byte leaves next cycle
                st_data_phase: begin
                    if (is_write) begin
                        state <= st_command;
                    end else begin
                        tx_start   <= 1'b1;
                        reply_left <= 2'(mfp_frame_data_bytes - 1);
                        state      <= st_reply;
                    end
                end
                st_reply: begin
                    if (tx_free) begin
                        if (reply_left == '0) begin
                            state <= st_command;
                        end else begin
                            tx_start   <= 1'b1;
                            reply_left <= reply_left - 1'b1;
                        end
                    end
                end
                default: state <= st_command;
            endcase
        end
    end

    // address, write data and reply bytes
    always_ff @(posedge clk) begin
        if (state == st_offset && rx_valid)
            haddr <= mfp_gpio_base + {24'h0, rx_data};
        if (state == st_data && rx_valid)
            hwdata <= {hwdata[23:0], rx_data};
        if (state == st_data_phase) begin
            tx_data <= hrdata[31:24];
            reply   <= hrdata[23:0];
        end else if (state == st_reply && tx_free && reply_left != '0) begin
            tx_data <= reply[23:16];
            reply   <= {reply[15:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

/* design/mfp_uart_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module mfp_uart_transmitter
    import mfp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);

    logic [mfp_uart_cnt_width-1:0] cnt;
    logic [3:0]                    bit_cnt;
    logic [8:0]                    shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_cnt <= '0;
            if (tx_start) begin
                // start bit goes out right away
                tx      <= 1'b0;
                tx_busy <= 1'b1;
            end
        end else if (cnt == mfp_uart_cnt_width'(mfp_uart_clks_per_bit - 1)) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // end of stop bit
                tx      <= 1'b1;
                tx_busy <= 1'b0;
            end else begin
                tx      <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // data bits then stop bit, shifted lsb first
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start)
            shift <= {1'b1, tx_data};
        else if (tx_busy && cnt == mfp_uart_cnt_width'(mfp_uart_clks_per_bit - 1))
            shift <= {1'b1, shift[8:1]};
    end

endmodule

`default_nettype wire

/* design/mfp_uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module mfp_uart_receiver
    import mfp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_bits,
        rx_stop
    } rx_state_t;

    rx_state_t                     state;
    logic                          rx_meta;
    logic                          rx_sync;
    logic [mfp_uart_cnt_width-1:0] cnt;
    logic [2:0]                    bit_idx;
    logic [7:0]                    shift;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= rx_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rx_sync)
                        state <= rx_start;
                end
                // wait half a bit and recheck, a glitch sends us back
                rx_start: begin
                    if (cnt == mfp_uart_cnt_width'(mfp_uart_half_bit - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? rx_idle : rx_bits;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_bits: begin
                    if (cnt == mfp_uart_cnt_width'(mfp_uart_clks_per_bit - 1)) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= rx_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // framing error drops the byte silently
                rx_stop: begin
                    if (cnt == mfp_uart_cnt_width'(mfp_uart_clks_per_bit - 1)) begin
                        rx_valid <= rx_sync;
                        state    <= rx_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first, sample at mid-bit
    always_ff @(posedge clk) begin
        if (state == rx_bits && cnt == mfp_uart_cnt_width'(mfp_uart_clks_per_bit - 1))
            shift <= {rx_sync, shift[7:1]};
    end

    assign rx_data = shift;

endmodule

`default_nettype wire

/* design/mfp_pkg.sv */
`default_nettype none

package mfp_pkg;

    // GPIO block address map
    localparam logic [31:0] mfp_gpio_base          = 32'h1f80_0000;
    localparam logic [31:0] mfp_red_leds_addr      = mfp_gpio_base + 32'h00;
    localparam logic [31:0] mfp_switches_addr      = mfp_gpio_base + 32'h08;
    localparam logic [31:0] mfp_buttons_addr       = mfp_gpio_base + 32'h0c;
    localparam logic [31:0] mfp_7_segment_hex_addr = mfp_gpio_base + 32'h10;

    // board I/O widths
    localparam int mfp_n_red_leds          = 10;
    localparam int mfp_n_switches          = 10;
    localparam int mfp_n_buttons           = 2;
    localparam int mfp_7_segment_hex_width = 24;

    // AHB-Lite HTRANS
    localparam logic [1:0] mfp_htrans_idle   = 2'b00;
    localparam logic [1:0] mfp_htrans_nonseq = 2'b10;

    // serial bit timing, kept short so that simulation stays fast
    localparam int mfp_uart_clks_per_bit = 8;
    localparam int mfp_uart_half_bit     = mfp_uart_clks_per_bit / 2;
    localparam int mfp_uart_cnt_width    = $clog2(mfp_uart_clks_per_bit);

    // frame command bytes ("W" and "R")
    localparam logic [7:0] mfp_cmd_write = 8'h57;
    localparam logic [7:0] mfp_cmd_read  = 8'h52;

    // data bytes in a write frame, and bytes in a read reply
    localparam int mfp_frame_data_bytes  = 4;

endpackage

`default_nettype wire
